// ==== Bender.yml ====
package:
  name: pc_io

sources:
  - logic/pc_io_pkg.sv
  - logic/io_port_decode.sv
  - logic/ppi_port_regs.sv
  - logic/speaker_tone.sv
  - logic/irq_toggle.sv
  - logic/pc_io_top.sv
  - target: test
    files:
      - sim/tb_clock.sv
      - sim/tb_pc_io.sv

// ==== all.f ====
logic/pc_io_pkg.sv
logic/io_port_decode.sv
logic/ppi_port_regs.sv
logic/speaker_tone.sv
logic/irq_toggle.sv
logic/pc_io_top.sv
sim/tb_clock.sv
sim/tb_pc_io.sv

// ==== logic/io_port_decode.sv ====
`timescale 1ns/1ps

module io_port_decode (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  wb_cyc_i,
   input  logic                  wb_stb_i,
   input  pc_io_pkg::wb_req_t    wb_req_i,
   output logic                  wb_ack_o,
   output pc_io_pkg::io_data_t   wb_dat_o,
   output pc_io_pkg::ppi_port_e  port_sel_o,
   output logic                  port_we_o,
   output pc_io_pkg::io_data_t   port_wdata_o,
   input  pc_io_pkg::io_data_t   port_rdata_i
);
   import pc_io_pkg::*;

   logic      in_block;   // address hits the 8255 block
   logic      req_new;    // request not yet acknowledged
   logic      ack_q;
   ppi_port_e port_sel;

   // a9..a8 zero and a7..a5 pick the block, a4..a2 are don't care
   assign in_block = (wb_req_i.addr[9:8] == 2'b00) &&
                     (wb_req_i.addr[7:5] == PPI_BLOCK);

   always_comb begin
      port_sel = PORT_NONE;
      if (in_block) begin
         case (wb_req_i.addr[1:0])
            2'd0:    port_sel = PORT_A;
            2'd1:    port_sel = PORT_B;
            2'd2:    port_sel = PORT_C;
            default: port_sel = PORT_CTRL;  // mode register, not kept
         endcase
      end
   end

   assign req_new = wb_cyc_i & wb_stb_i & ~ack_q;

   // single cycle ack, never stalls
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req_new;
      end
   end

   // strobe lands on the edge that raises ack
   assign port_we_o    = req_new & wb_req_i.we;
   assign port_sel_o   = port_sel;
   assign port_wdata_o = wb_req_i.wdata;
   assign wb_ack_o     = ack_q;

   // unclaimed ports float high on the bus
   always_comb begin
      case (port_sel)
         PORT_A,
         PORT_B,
         PORT_C:  wb_dat_o = port_rdata_i;
         default: wb_dat_o = 8'hFF;
      endcase
   end

endmodule

// ==== logic/irq_toggle.sv ====
`timescale 1ns/1ps

module irq_toggle (
   input  logic clk,
   input  logic reset_n,
   input  logic irq_button_i,
   output logic irq_en_o
);
   import pc_io_pkg::*;

   logic          btn_meta;
   logic          btn_sync;
   toggle_state_e state;
   toggle_state_e state_nxt;

   // two-flop synchronizer for the button
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         btn_meta <= 1'b0;
         btn_sync <= 1'b0;
      end else begin
         btn_meta <= irq_button_i;
         btn_sync <= btn_meta;
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state <= ST_ON;   // irq0 enabled out of reset
      end else begin
         state <= state_nxt;
      end
   end

   // press arms, release commits the toggle
   always_comb begin
      state_nxt = state;
      case (state)
         ST_ON:       if (btn_sync)  state_nxt = ST_WAIT_OFF;
         ST_WAIT_OFF: if (!btn_sync) state_nxt = ST_OFF;
         ST_OFF:      if (btn_sync)  state_nxt = ST_WAIT_ON;
         ST_WAIT_ON:  if (!btn_sync) state_nxt = ST_ON;
         default:     state_nxt = ST_ON;
      endcase
   end

   assign irq_en_o = (state == ST_ON) || (state == ST_WAIT_OFF);

endmodule

// ==== logic/pc_io_pkg.sv ====
package pc_io_pkg;

   // i/o port address and data byte
   typedef logic [9:0] io_addr_t;
   typedef logic [7:0] io_data_t;

   // wishbone request, held stable by the master until ack
   typedef struct packed {
      io_addr_t addr;
      io_data_t wdata;
      logic     we;    // 1 = write
   } wb_req_t;

   // decoded target inside the 8255 block
   typedef enum logic [2:0] {
      PORT_NONE,
      PORT_A,
      PORT_B,
      PORT_C,
      PORT_CTRL
   } ppi_port_e;

   // port b bit layout, msb first
   typedef struct packed {
      logic kbd_clear;      // also selects switch bank 1 onto port a
      logic kbd_clk_low;
      logic io_ck_en_n;
      logic ram_pck_en_n;
      logic motor_off;
      logic sw_nibble_sel;  // 1 = low nibble of switch bank 2
      logic spkr_data;
      logic tim2_gate;
   } ppi_ctrl_t;

   // irq0 enable button fsm
   typedef enum logic [1:0] {
      ST_ON,
      ST_WAIT_OFF,
      ST_OFF,
      ST_WAIT_ON
   } toggle_state_e;

   localparam logic [2:0] PPI_BLOCK = 3'd3;  // 0x060..0x07f

   localparam logic [11:0] DEF_TONE_RELOAD    = 12'h533;
   localparam logic [11:0] DEF_TONE_THRESHOLD = 12'h299;
   localparam int          DEF_TICK_DIV       = 2;
   localparam logic [7:0]  DEF_SW1            = 8'h2C;
   localparam logic [3:0]  DEF_SW2_LO         = 4'h6;
   localparam logic [3:0]  DEF_SW2_HI         = 4'hE;

endpackage

// ==== logic/pc_io_top.sv ====
`timescale 1ns/1ps

module pc_io_top #(
   parameter logic [11:0] TONE_RELOAD    = pc_io_pkg::DEF_TONE_RELOAD,
   parameter logic [11:0] TONE_THRESHOLD = pc_io_pkg::DEF_TONE_THRESHOLD,
   parameter int          TICK_DIV       = pc_io_pkg::DEF_TICK_DIV,
   parameter logic [7:0]  SW1            = pc_io_pkg::DEF_SW1,
   parameter logic [3:0]  SW2_LO         = pc_io_pkg::DEF_SW2_LO,
   parameter logic [3:0]  SW2_HI         = pc_io_pkg::DEF_SW2_HI
) (
   input  logic                clk,
   input  logic                reset_n,
   input  logic                wb_cyc_i,
   input  logic                wb_stb_i,
   input  pc_io_pkg::wb_req_t  wb_req_i,
   output logic                wb_ack_o,
   output pc_io_pkg::io_data_t wb_dat_o,
   input  logic                irq_button_i,
   output logic                speaker_o,
   output logic                motor_off_o,
   output logic                irq_en_o
);
   import pc_io_pkg::*;

   ppi_port_e port_sel;
   logic      port_we;
   io_data_t  port_wdata;
   io_data_t  port_rdata;
   ppi_ctrl_t ppi_ctrl;   // port b contents
   logic      tone_level;

   io_port_decode u_decode (
      .clk, .reset_n, .wb_cyc_i, .wb_stb_i, .wb_req_i, .wb_ack_o, .wb_dat_o,
      .port_sel_o(port_sel), .port_we_o(port_we), .port_wdata_o(port_wdata),
      .port_rdata_i(port_rdata)
   );

   ppi_port_regs #(.SW1(SW1), .SW2_LO(SW2_LO), .SW2_HI(SW2_HI)) u_ppi (
      .clk, .reset_n, .port_sel_i(port_sel), .port_we_i(port_we),
      .port_wdata_i(port_wdata), .port_rdata_o(port_rdata),
      .tone_level_i(tone_level), .ctrl_o(ppi_ctrl)
   );

   speaker_tone #(
      .TONE_RELOAD(TONE_RELOAD),
      .TONE_THRESHOLD(TONE_THRESHOLD),
      .TICK_DIV(TICK_DIV)
   ) u_tone (
      .clk, .reset_n, .ctrl_i(ppi_ctrl), .tone_level_o(tone_level), .speaker_o
   );

   irq_toggle u_irq (.clk, .reset_n, .irq_button_i, .irq_en_o);

   assign motor_off_o = ppi_ctrl.motor_off;  // port b bit 3

endmodule

// ==== logic/ppi_port_regs.sv ====
`timescale 1ns/1ps

module ppi_port_regs #(
   parameter logic [7:0] SW1    = pc_io_pkg::DEF_SW1,
   parameter logic [3:0] SW2_LO = pc_io_pkg::DEF_SW2_LO,
   parameter logic [3:0] SW2_HI = pc_io_pkg::DEF_SW2_HI
) (
   input  logic                  clk,
   input  logic                  reset_n,
   input  pc_io_pkg::ppi_port_e  port_sel_i,
   input  logic                  port_we_i,
   input  pc_io_pkg::io_data_t   port_wdata_i,
   output pc_io_pkg::io_data_t   port_rdata_o,
   input  logic                  tone_level_i,
   output pc_io_pkg::ppi_ctrl_t  ctrl_o
);
   import pc_io_pkg::*;

   ppi_ctrl_t port_b;
   io_data_t  port_a;
   io_data_t  port_c;
   logic [3:0] sw2_nibble;

   // port b, the only writable port
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         port_b <= '0;
      end else if (port_we_i && (port_sel_i == PORT_B)) begin
         port_b <= ppi_ctrl_t'(port_wdata_i);
      end
   end

   // no keyboard behind port a, so it only shows the switches
   assign port_a = port_b.kbd_clear ? SW1 : 8'h00;

   assign sw2_nibble = port_b.sw_nibble_sel ? SW2_LO : SW2_HI;

   // pc7..pc6 parity and channel check are gone
   assign port_c = {2'b00, tone_level_i, ~tone_level_i, sw2_nibble};

   always_comb begin
      case (port_sel_i)
         PORT_A:  port_rdata_o = port_a;
         PORT_B:  port_rdata_o = io_data_t'(port_b);
         PORT_C:  port_rdata_o = port_c;
         default: port_rdata_o = 8'hFF;
      endcase
   end

   assign ctrl_o = port_b;

endmodule

// ==== logic/speaker_tone.sv ====
`timescale 1ns/1ps

module speaker_tone #(
   parameter logic [11:0] TONE_RELOAD    = pc_io_pkg::DEF_TONE_RELOAD,
   parameter logic [11:0] TONE_THRESHOLD = pc_io_pkg::DEF_TONE_THRESHOLD,
   parameter int          TICK_DIV       = pc_io_pkg::DEF_TICK_DIV
) (
   input  logic                 clk,
   input  logic                 reset_n,
   input  pc_io_pkg::ppi_ctrl_t ctrl_i,
   output logic                 tone_level_o,
   output logic                 speaker_o
);

   localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

   logic [DIV_W-1:0] div_cnt;
   logic             tick;
   logic [11:0]      tone_cnt;   // free running, counts down

   assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));

   // tick divider
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         div_cnt <= '0;
      end else if (tick) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // reload down-counter, wraps from 0 back to the reload value
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         tone_cnt <= TONE_RELOAD;
      end else if (tick) begin
         if (tone_cnt == 12'h000) begin
            tone_cnt <= TONE_RELOAD;
         end else begin
            tone_cnt <= tone_cnt - 12'd1;
         end
      end
   end

   // square wave from the upper part of the count, high when gate is off
   assign tone_level_o = ctrl_i.tim2_gate ? (tone_cnt >= TONE_THRESHOLD) : 1'b1;

   assign speaker_o = tone_level_o & ctrl_i.spkr_data;  // keyed by port b bit 1

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic reset_n
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;  // 100 ns period
   end

   // reset held low over the first 3 rising edges
   initial begin
      reset_n = 1'b0;
      repeat (3) @(posedge clk);
      reset_n <= 1'b1;
   end

endmodule

// ==== sim/tb_pc_io.sv ====
`timescale 1ns/1ps

module tb_pc_io;
   import pc_io_pkg::*;

   localparam logic [11:0] TONE_RELOAD    = 12'd20;
   localparam logic [11:0] TONE_THRESHOLD = 12'd8;
   localparam int          TICK_DIV       = 2;
   localparam logic [7:0]  SW1            = 8'h2C;
   localparam logic [3:0]  SW2_LO         = 4'h6;
   localparam logic [3:0]  SW2_HI         = 4'hE;
   localparam int ACK_TIMEOUT  = 8;
   localparam int WAVE_TIMEOUT = 100;
   // tone timing from the down-counter rules
   localparam int HIGH_CLKS   = (int'(TONE_RELOAD) - int'(TONE_THRESHOLD) + 1) * TICK_DIV;
   localparam int PERIOD_CLKS = (int'(TONE_RELOAD) + 1) * TICK_DIV;

   logic     clk;
   logic     reset_n;
   logic     wb_cyc;
   logic     wb_stb;
   wb_req_t  wb_req;
   logic     wb_ack;
   io_data_t wb_dat;
   logic     irq_button;
   logic     speaker;
   logic     motor_off;
   logic     irq_en;
   int       error_count;
   int       test_count;
   int       failed_tests;
   integer   seed;

   tb_clock clk_gen (.clk, .reset_n);

   pc_io_top #(
      .TONE_RELOAD(TONE_RELOAD), .TONE_THRESHOLD(TONE_THRESHOLD), .TICK_DIV(TICK_DIV),
      .SW1(SW1), .SW2_LO(SW2_LO), .SW2_HI(SW2_HI)
   ) dut0 (
      .clk, .reset_n, .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_req_i(wb_req),
      .wb_ack_o(wb_ack), .wb_dat_o(wb_dat), .irq_button_i(irq_button),
      .speaker_o(speaker), .motor_off_o(motor_off), .irq_en_o(irq_en)
   );

   task automatic check_data(input string what, input io_data_t got, input io_data_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s gave %02h, expected %02h", $time, what, got, exp);
         error_count++;
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
         error_count++;
      end
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      if (got != exp) begin
         $display("[ERROR] %0t ns: %s was %0d clocks, expected %0d", $time, what, got, exp);
         error_count++;
      end
   endtask

   // one classic cycle, request held until ack, then stb dropped
   task automatic bus_access(input io_addr_t addr, input io_data_t wdata, input logic we,
                             output io_data_t rdata);
      wb_req_t req;
      logic    acked;
      int      n;
      req.addr  = addr;
      req.wdata = wdata;
      req.we    = we;
      acked     = 1'b0;
      rdata     = 8'hXX;
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_req <= req;
      for (n = 0; n < ACK_TIMEOUT && !acked; n++) begin
         @(negedge clk);
         acked = (wb_ack === 1'b1);
      end
      if (acked) rdata = wb_dat;  // valid in the ack cycle
      else begin
         $display("no acknowledge for port %03h within %0d clocks", addr, ACK_TIMEOUT);
         error_count++;
      end
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_req <= '0;
   endtask

   task automatic wb_write(input io_addr_t addr, input io_data_t data);
      io_data_t unused;
      bus_access(addr, data, 1'b1, unused);
   endtask

   task automatic wb_read(input io_addr_t addr, output io_data_t data);
      bus_access(addr, 8'h00, 1'b0, data);
   endtask

   // counts clocks until the speaker reaches a level
   task automatic wait_speaker(input logic level, output int cycles);
      logic seen;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < WAVE_TIMEOUT) begin
         @(negedge clk);
         cycles++;
         seen = (speaker === level);
      end
      if (!seen) begin
         $display("speaker never reached %b within %0d clocks", level, WAVE_TIMEOUT);
         error_count++;
      end
   endtask

   task automatic hold_speaker(input logic level, input int cycles);
      logic seen;
      seen = level;
      repeat (cycles) begin
         @(negedge clk);
         if (speaker !== level) seen = speaker;
      end
      check_bit("speaker while held", seen, level);
   endtask

   // irq enable keeps its old level until the button is released
   task automatic press_release(input logic level);
      @(posedge clk);
      irq_button <= 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_bit("irq enable while pressed", irq_en, level);
      @(posedge clk);
      irq_button <= 1'b0;
   endtask

   task automatic wait_irq_en(input logic level);
      logic seen;
      int   n;
      seen = 1'b0;
      for (n = 0; n < 5 && !seen; n++) begin
         @(negedge clk);
         seen = (irq_en === level);
      end
      check_bit("irq enable after release", irq_en, level);
   endtask

   task automatic report_test(input string name, input int errors_before);
      test_count++;
      if (error_count > errors_before) begin
         failed_tests++;
         $display("test %0d %-14s : %0d errors", test_count, name, error_count - errors_before);
      end else begin
         $display("test %0d %-14s : ok", test_count, name);
      end
   endtask

   task automatic reset_defaults;
      io_data_t d;
      int       start;
      start = error_count;
      wb_read(10'h061, d);
      check_data("port B after reset", d, 8'h00);
      @(negedge clk);
      check_bit("speaker_o after reset", speaker, 1'b0);
      check_bit("motor_off_o after reset", motor_off, 1'b0);
      check_bit("irq_en_o after reset", irq_en, 1'b1);
      report_test("reset state", start);
   endtask

   task automatic write_readback(input io_data_t v);
      io_data_t d;
      wb_write(10'h061, v);
      wb_read(10'h061, d);
      check_data("port B readback", d, v);
      @(negedge clk);
      check_bit("motor_off_o", motor_off, v[3]);
   endtask

   task automatic port_b_access;
      io_data_t    d;
      io_data_t    v;
      logic [31:0] rnd;
      int          start;
      start = error_count;
      write_readback(8'hA5);
      write_readback(8'h5A);
      repeat (4) begin
         rnd = $random(seed);
         v   = rnd[7:0];
         write_readback(v);
      end
      // outside the 8255 block, port B keeps its value
      wb_write(10'h021, ~v);
      wb_write(10'h161, ~v);
      wb_read(10'h061, d);
      check_data("port B after foreign writes", d, v);
      wb_read(10'h021, d);
      check_data("read of 0x021", d, 8'hFF);
      wb_read(10'h161, d);
      check_data("read of 0x161", d, 8'hFF);
      report_test("port B decode", start);
   endtask

   task automatic switch_readback;
      io_data_t d;
      int       start;
      start = error_count;
      wb_write(10'h061, 8'h00);
      wb_read(10'h060, d);
      check_data("port A, bit 7 clear", d, 8'h00);
      wb_write(10'h061, 8'h80);
      wb_read(10'h060, d);
      check_data("port A, bit 7 set", d, SW1);
      // gate clear keeps the tone level high, so PC5 set and PC4 clear
      wb_write(10'h061, 8'h04);
      wb_read(10'h062, d);
      check_data("port C, bit 2 set", d, {4'b0010, SW2_LO});
      wb_write(10'h061, 8'h00);
      wb_read(10'h062, d);
      check_data("port C, bit 2 clear", d, {4'b0010, SW2_HI});
      report_test("switch read", start);
   endtask

   task automatic tone_waveform;
      int high_t;
      int low_t;
      int n;
      int start;
      start = error_count;
      wb_write(10'h061, 8'h03);
      wait_speaker(1'b0, n);
      wait_speaker(1'b1, n);       // now at a rising edge
      wait_speaker(1'b0, high_t);
      wait_speaker(1'b1, low_t);
      check_count("speaker high time", high_t, HIGH_CLKS);
      check_count("speaker period", high_t + low_t, PERIOD_CLKS);
      wb_write(10'h061, 8'h01);
      hold_speaker(1'b0, 2 * PERIOD_CLKS);
      wb_write(10'h061, 8'h02);
      hold_speaker(1'b1, 2 * PERIOD_CLKS);
      report_test("tone waveform", start);
   endtask

   task automatic tone_status;
      io_data_t d;
      int       n;
      int       start;
      start = error_count;
      wb_write(10'h061, 8'h03);
      wait_speaker(1'b0, n);
      wait_speaker(1'b1, n);
      wb_read(10'h062, d);         // well inside the high phase
      check_data("port C during high phase", d, {4'b0010, SW2_HI});
      report_test("tone status", start);
   endtask

   task automatic button_toggle;
      int start;
      start = error_count;
      press_release(1'b1);
      wait_irq_en(1'b0);
      press_release(1'b0);
      wait_irq_en(1'b1);
      report_test("irq toggle", start);
   endtask

   initial begin
      int n;
      wb_cyc       = 1'b0;
      wb_stb       = 1'b0;
      wb_req       = '0;
      irq_button   = 1'b0;
      error_count  = 0;
      test_count   = 0;
      failed_tests = 0;
      seed         = 56;
      n            = 0;
      while (reset_n !== 1'b1 && n < 10) begin
         @(negedge clk);
         n++;
      end
      if (reset_n !== 1'b1) begin
         $display("reset was never released");
         error_count++;
      end
      reset_defaults();
      port_b_access();
      switch_readback();
      tone_waveform();
      tone_status();
      button_toggle();
      $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, error_count);
      if (error_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
